//--- design/rdcmp_consts.svh
// Read checker constants for widths, LFSR seeds, queue depths and byte-enable mode
`ifndef RDCMP_CONSTS_SVH
`define RDCMP_CONSTS_SVH

// Data path
`define RDCMP_DATA_WIDTH       32
`define RDCMP_BE_WIDTH         4
`define RDCMP_BYTE_SIZE        8

// Low two bits of an exact address are always zero
`define RDCMP_ADDR_WIDTH       24
`define RDCMP_WORD_ADDR_WIDTH  22
`define RDCMP_SIZE_WIDTH       6

// Queue depths
`define RDCMP_ADDR_FIFO_DEPTH  8
`define RDCMP_CREDIT_DEPTH     16

// Pattern seeds shared with the traffic generator
`define RDCMP_DATA_SEED        32'h5a3c_96e1
`define RDCMP_BE_SEED          4'b1011

// 1 gives random byte enables, 0 keeps every lane enabled
`define RDCMP_RANDOM_BE        1

`define RDCMP_CNT_WIDTH        32

`endif

//--- design/mem_txn_pkg.sv
// Read traffic types for queued read requests and returned data beats
`include "rdcmp_consts.svh"

package mem_txn_pkg;

   //////////////////////////////
   // Queued read
   //////////////////////////////

   // One entry of the burst tracker FIFO
   typedef struct packed {
      logic [`RDCMP_ADDR_WIDTH-1:0] addr;
      logic [`RDCMP_SIZE_WIDTH-1:0] burst;
   } read_req_t;

   //////////////////////////////
   // Returned beat
   //////////////////////////////

   // A read data beat after the alignment pipe
   typedef struct packed {
      logic                         valid;
      logic [`RDCMP_DATA_WIDTH-1:0] data;
   } beat_t;

endpackage

//--- design/check_pkg.sv
// Check result types for per-beat compare results and the first-fail record
`include "rdcmp_consts.svh"

package check_pkg;

   //////////////////////////////
   // Per-beat compare result
   //////////////////////////////

   // pnf holds one pass bit per data bit, all ones when idle
   typedef struct packed {
      logic                         active;
      logic [`RDCMP_DATA_WIDTH-1:0] pnf;
      logic [`RDCMP_ADDR_WIDTH-1:0] addr;
   } compare_t;

   //////////////////////////////
   // First failure
   //////////////////////////////

   // Held from the first failing beat until reset
   typedef struct packed {
      logic                         captured;
      logic [`RDCMP_ADDR_WIDTH-1:0] addr;
      logic [`RDCMP_DATA_WIDTH-1:0] pnf;
   } fail_rec_t;

endpackage

//--- design/pattern_lfsr.sv
// Seeded pattern LFSR that advances one step per enabled cycle
`timescale 1ns/1ps

module pattern_lfsr #(
   parameter int               WIDTH = 32,
   parameter logic [WIDTH-1:0] SEED  = '1
) (
   input  logic             clk,
   input  logic             reset_n,
   input  logic             enable,
   output logic [WIDTH-1:0] value
);

   localparam int TAP = WIDTH / 2;

   logic [WIDTH-1:0] next_value;

   // Shift left, feedback from the two top bits into bit 0
   always_comb begin
      next_value      = {value[WIDTH-2:0], value[WIDTH-1] ^ value[WIDTH-2]};
      // Galois tap in the middle of the register
      next_value[TAP] = value[TAP-1] ^ value[0];
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         value <= SEED;
      end else if (enable) begin
         value <= next_value;
      end
   end

endmodule

//--- design/expected_data_gen.sv
// Expected write data and per-bit byte mask regenerated from seeded LFSRs
`timescale 1ns/1ps
`include "rdcmp_consts.svh"

module expected_data_gen (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         step,
   output logic [`RDCMP_DATA_WIDTH-1:0] exp_data,
   output logic [`RDCMP_DATA_WIDTH-1:0] exp_mask
);

   localparam int BE_WIDTH  = `RDCMP_BE_WIDTH;
   localparam int BYTE_SIZE = `RDCMP_BYTE_SIZE;

   logic [BE_WIDTH-1:0] exp_be;

   // Same seed as the generator, so the sequence repeats in write order
   pattern_lfsr #(
      .WIDTH   (`RDCMP_DATA_WIDTH),
      .SEED    (`RDCMP_DATA_SEED)
   ) data_lfsr_inst (
      .clk     (clk),
      .reset_n (reset_n),
      .enable  (step),
      .value   (exp_data)
   );

   if (`RDCMP_RANDOM_BE == 1) begin : gen_be_lfsr
      pattern_lfsr #(
         .WIDTH   (BE_WIDTH),
         .SEED    (`RDCMP_BE_SEED)
      ) be_lfsr_inst (
         .clk     (clk),
         .reset_n (reset_n),
         .enable  (step),
         .value   (exp_be)
      );
   end else begin : gen_be_const
      assign exp_be = '1;
   end

   // Spread each byte enable over its lane
   for (genvar lane = 0; lane < BE_WIDTH; lane++) begin : gen_mask
      assign exp_mask[lane*BYTE_SIZE +: BYTE_SIZE] = {BYTE_SIZE{exp_be[lane]}};
   end

endmodule

//--- design/burst_tracker.sv
// Read burst tracker giving the exact word address of every returned beat
`timescale 1ns/1ps
`include "rdcmp_consts.svh"

module burst_tracker
   import mem_txn_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         push,
   input  read_req_t                    read_req,
   input  logic                         beat_valid,
   output logic [`RDCMP_ADDR_WIDTH-1:0] beat_addr
);

   localparam int DEPTH     = `RDCMP_ADDR_FIFO_DEPTH;
   localparam int PTR_WIDTH = $clog2(DEPTH);
   localparam int AW        = `RDCMP_ADDR_WIDTH;
   localparam int WAW       = `RDCMP_WORD_ADDR_WIDTH;
   localparam int SW        = `RDCMP_SIZE_WIDTH;
   localparam int LOW_BITS  = AW - WAW;

   typedef enum logic {
      WAIT_REQ  = 1'b0,
      WAIT_DATA = 1'b1
   } state_t;

   logic                 push_r;
   read_req_t            req_r;
   read_req_t            fifo_mem [DEPTH];
   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [PTR_WIDTH:0]   fifo_count;
   logic                 fifo_empty;
   read_req_t            fifo_head;
   logic                 pop;

   state_t               state;
   state_t               nxt_state;
   logic [WAW-1:0]       base_word;
   logic [WAW-1:0]       nxt_base_word;
   logic [SW-1:0]        burst_len;
   logic [SW-1:0]        nxt_burst_len;
   logic [SW-1:0]        beats_left;
   logic [SW-1:0]        nxt_beats_left;
   logic [WAW-1:0]       beat_index;

   //////////////////////////////
   // Request FIFO
   //////////////////////////////

   // Extra register stage in front of the FIFO
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         push_r <= 1'b0;
      end else begin
         push_r <= push;
      end
   end

   always_ff @(posedge clk) begin
      req_r <= read_req;
      if (push_r) begin
         fifo_mem[wr_ptr] <= req_r;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_count <= '0;
      end else begin
         if (push_r) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_r, pop})
            2'b10:   fifo_count <= fifo_count + 1'b1;
            2'b01:   fifo_count <= fifo_count - 1'b1;
            default: fifo_count <= fifo_count;
         endcase
      end
   end

   // Show-ahead head of queue
   assign fifo_head  = fifo_mem[rd_ptr];
   assign fifo_empty = (fifo_count == '0);

   //////////////////////////////
   // Burst FSM
   //////////////////////////////

   always_comb begin
      nxt_state      = state;
      nxt_base_word  = base_word;
      nxt_burst_len  = burst_len;
      nxt_beats_left = beats_left;
      pop            = 1'b0;

      case (state)
         WAIT_REQ: begin
            if (!fifo_empty) begin
               nxt_state = WAIT_DATA;
               pop       = 1'b1;
            end
         end
         WAIT_DATA: begin
            if (beat_valid) begin
               if (beats_left != '0) begin
                  nxt_beats_left = beats_left - 1'b1;
               end else if (!fifo_empty) begin
                  // Next burst follows without a gap
                  pop = 1'b1;
               end else begin
                  nxt_state = WAIT_REQ;
               end
            end
         end
      endcase

      if (pop) begin
         nxt_base_word  = fifo_head.addr[AW-1 -: WAW];
         nxt_burst_len  = fifo_head.burst;
         nxt_beats_left = fifo_head.burst - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state      <= WAIT_REQ;
         base_word  <= '0;
         burst_len  <= '0;
         beats_left <= '0;
      end else begin
         state      <= nxt_state;
         base_word  <= nxt_base_word;
         burst_len  <= nxt_burst_len;
         beats_left <= nxt_beats_left;
      end
   end

   // Index of the current beat within its burst
   assign beat_index = {{(WAW-SW){1'b0}}, burst_len - beats_left - 1'b1};
   assign beat_addr  = {base_word + beat_index, {LOW_BITS{1'b0}}};

endmodule

//--- design/bit_compare.sv
// Bitwise pass/fail of a returned beat against expected data under the byte mask
`timescale 1ns/1ps
`include "rdcmp_consts.svh"

module bit_compare
   import mem_txn_pkg::*;
   import check_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         enable,
   input  beat_t                        beat,
   input  logic [`RDCMP_DATA_WIDTH-1:0] exp_data,
   input  logic [`RDCMP_DATA_WIDTH-1:0] exp_mask,
   input  logic [`RDCMP_ADDR_WIDTH-1:0] beat_addr,
   output compare_t                     result
);

   localparam int DW = `RDCMP_DATA_WIDTH;

   logic          check;
   logic [DW-1:0] mismatch;
   logic [DW-1:0] pnf;

   // A beat is checked only while enabled
   assign check = enable & beat.valid;

   // Differences only count in enabled byte lanes
   assign mismatch = (beat.data ^ exp_data) & exp_mask;

   // Idle cycles and disabled lanes report a pass
   assign pnf = ~(mismatch & {DW{check}});

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         result.active <= 1'b0;
         result.pnf    <= '1;
         result.addr   <= '0;
      end else begin
         result.active <= check;
         result.pnf    <= pnf;
         result.addr   <= beat_addr;
      end
   end

endmodule

//--- design/fail_logger.sv
// Compare and fail statistics with capture of the first failing beat
`timescale 1ns/1ps
`include "rdcmp_consts.svh"

module fail_logger
   import check_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset_n,
   input  compare_t                    result,
   output fail_rec_t                   fail_rec,
   output logic [`RDCMP_CNT_WIDTH-1:0] compare_count,
   output logic [`RDCMP_CNT_WIDTH-1:0] fail_count
);

   logic has_fail;

   // Any cleared pass bit marks the beat as failing
   assign has_fail = ~(&result.pnf);

   //////////////////////////////
   // Statistics
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         compare_count <= '0;
         fail_count    <= '0;
      end else begin
         if (result.active) begin
            compare_count <= compare_count + 1'b1;
         end
         if (has_fail) begin
            fail_count <= fail_count + 1'b1;
         end
      end
   end

   //////////////////////////////
   // First failure
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         fail_rec.captured <= 1'b0;
         fail_rec.addr     <= '0;
         fail_rec.pnf      <= '1;
      end else if (has_fail && !fail_rec.captured) begin
         fail_rec.captured <= 1'b1;
         fail_rec.addr     <= result.addr;
         fail_rec.pnf      <= result.pnf;
      end
   end

endmodule

//--- design/read_compare_top.sv
// Read data checker top with beat alignment pipe and compare request credits
`timescale 1ns/1ps
`include "rdcmp_consts.svh"

module read_compare_top
   import mem_txn_pkg::*;
   import check_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         enable,
   input  logic                         queue_read_req,
   input  read_req_t                    read_req,
   input  logic                         queue_compare_req,
   input  logic                         rdata_valid,
   input  logic [`RDCMP_DATA_WIDTH-1:0] rdata,
   output logic [`RDCMP_DATA_WIDTH-1:0] pnf_per_bit,
   output logic                         compare_valid,
   output logic                         captured_first_fail,
   output logic [`RDCMP_ADDR_WIDTH-1:0] first_fail_addr,
   output logic [`RDCMP_DATA_WIDTH-1:0] first_fail_pnf,
   output logic [`RDCMP_CNT_WIDTH-1:0]  compare_count,
   output logic [`RDCMP_CNT_WIDTH-1:0]  fail_count,
   output logic                         compare_full,
   output logic                         compare_empty
);

   // Two guard bits above the depth, sign bit means empty
   localparam int CREDIT_WIDTH = $clog2(`RDCMP_CREDIT_DEPTH) + 2;

   beat_t                          beat_r;
   beat_t                          beat_r2;
   logic                           compare_req_r;
   logic                           compare_req_r2;
   logic [CREDIT_WIDTH-1:0]        credit_count;
   logic                           step;
   logic [`RDCMP_DATA_WIDTH-1:0]   exp_data;
   logic [`RDCMP_DATA_WIDTH-1:0]   exp_mask;
   logic [`RDCMP_ADDR_WIDTH-1:0]   beat_addr;
   compare_t                       result;
   fail_rec_t                      fail_rec;

   //////////////////////////////
   // Alignment pipes
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         beat_r         <= '0;
         beat_r2        <= '0;
         compare_req_r  <= 1'b0;
         compare_req_r2 <= 1'b0;
      end else begin
         beat_r         <= '{valid: rdata_valid, data: rdata};
         beat_r2        <= beat_r;
         compare_req_r  <= queue_compare_req;
         compare_req_r2 <= compare_req_r;
      end
   end

   //////////////////////////////
   // Compare request credits
   //////////////////////////////

   // Starts at -1, a request and a beat in the same cycle cancel out
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         credit_count <= '1;
      end else if (enable && compare_req_r2 && !beat_r.valid) begin
         credit_count <= credit_count + 1'b1;
      end else if (enable && beat_r.valid && !compare_req_r2) begin
         credit_count <= credit_count - 1'b1;
      end
   end

   assign compare_full  = (credit_count[CREDIT_WIDTH-1 -: 2] == 2'b01);
   assign compare_empty = credit_count[CREDIT_WIDTH-1];

   //////////////////////////////
   // Check path
   //////////////////////////////

   assign step = enable & beat_r2.valid;

   expected_data_gen expected_data_gen_inst (
      .clk        (clk),
      .reset_n    (reset_n),
      .step       (step),
      .exp_data   (exp_data),
      .exp_mask   (exp_mask)
   );

   burst_tracker burst_tracker_inst (
      .clk        (clk),
      .reset_n    (reset_n),
      .push       (queue_read_req),
      .read_req   (read_req),
      .beat_valid (beat_r2.valid),
      .beat_addr  (beat_addr)
   );

   bit_compare bit_compare_inst (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (enable),
      .beat       (beat_r2),
      .exp_data   (exp_data),
      .exp_mask   (exp_mask),
      .beat_addr  (beat_addr),
      .result     (result)
   );

   fail_logger fail_logger_inst (
      .clk           (clk),
      .reset_n       (reset_n),
      .result        (result),
      .fail_rec      (fail_rec),
      .compare_count (compare_count),
      .fail_count    (fail_count)
   );

   assign pnf_per_bit         = result.pnf;
   assign compare_valid       = result.active;
   assign captured_first_fail = fail_rec.captured;
   assign first_fail_addr     = fail_rec.addr;
   assign first_fail_pnf      = fail_rec.pnf;

endmodule

//--- bench/tb_read_compare.sv
// Testbench for the read data checker with a reference pattern model and assertions
`timescale 1ns/1ps
`include "rdcmp_consts.svh"

module tb_read_compare
   import mem_txn_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int DW           = `RDCMP_DATA_WIDTH;
   localparam int AW           = `RDCMP_ADDR_WIDTH;
   localparam int WAW          = `RDCMP_WORD_ADDR_WIDTH;
   localparam int SW           = `RDCMP_SIZE_WIDTH;
   localparam int BEW          = `RDCMP_BE_WIDTH;
   localparam int DEPTH        = `RDCMP_CREDIT_DEPTH;
   localparam int CLEAN_GROUPS = 6;
   localparam int FLIP_GROUPS  = 4;
   localparam int GROUP_BURSTS = 2;
   localparam int MAX_BEATS    = (CLEAN_GROUPS + FLIP_GROUPS) * GROUP_BURSTS * 8 + DEPTH + 1;
   localparam int WATCHDOG_NS  = (MAX_BEATS * 4 + RESET_CYCLES + 400) * CLK_PERIOD;

   logic                        clk;
   logic                        reset_n;
   logic                        enable;
   logic                        queue_read_req;
   read_req_t                   read_req;
   logic                        queue_compare_req;
   logic                        rdata_valid;
   logic [DW-1:0]               rdata;
   logic [DW-1:0]               pnf_per_bit;
   logic                        compare_valid;
   logic                        captured_first_fail;
   logic [AW-1:0]               first_fail_addr;
   logic [DW-1:0]               first_fail_pnf;
   logic [`RDCMP_CNT_WIDTH-1:0] compare_count;
   logic [`RDCMP_CNT_WIDTH-1:0] fail_count;
   logic                        compare_full;
   logic                        compare_empty;

   // Expected result of the beat being driven
   logic [DW-1:0]               beat_pnf;
   logic [AW-1:0]               beat_addr;
   logic [DW-1:0]               data_state;
   logic [BEW-1:0]              be_state;
   int                          burst_lens[$];
   int                          beats_sent;
   int                          error_count;

   // Reference timing model
   logic [2:0]                  pipe_valid;
   logic [2:0][DW-1:0]          pipe_pnf;
   logic [2:0][AW-1:0]          pipe_addr;
   logic                        req_d1;
   logic                        req_d2;
   logic                        beat_d1;
   int                          model_credit;
   int                          model_compares;
   int                          model_fails;
   logic                        model_captured;
   logic [AW-1:0]               model_ff_addr;
   logic [DW-1:0]               model_ff_pnf;

   read_compare_top read_compare_top_inst (
      .clk                 (clk),
      .reset_n             (reset_n),
      .enable              (enable),
      .queue_read_req      (queue_read_req),
      .read_req            (read_req),
      .queue_compare_req   (queue_compare_req),
      .rdata_valid         (rdata_valid),
      .rdata               (rdata),
      .pnf_per_bit         (pnf_per_bit),
      .compare_valid       (compare_valid),
      .captured_first_fail (captured_first_fail),
      .first_fail_addr     (first_fail_addr),
      .first_fail_pnf      (first_fail_pnf),
      .compare_count       (compare_count),
      .fail_count          (fail_count),
      .compare_full        (compare_full),
      .compare_empty       (compare_empty)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   task automatic fail_run(input string msg);
      error_count++;
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      fail_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // One pattern step shifts left with the top two bits feeding bit 0 and bit 0 in the middle
   function automatic logic [DW-1:0] lfsr_step(input logic [DW-1:0] v, input int width);
      logic [DW-1:0] n;
      n = '0;
      for (int i = 1; i < width; i++) begin
         n[i] = v[i-1];
      end
      n[0]         = v[width-1] ^ v[width-2];
      n[width / 2] = v[width/2 - 1] ^ v[0];
      return n;
   endfunction

   function automatic logic [DW-1:0] lane_mask(input logic [BEW-1:0] be);
      logic [DW-1:0] m;
      for (int lane = 0; lane < BEW; lane++) begin
         m[lane*`RDCMP_BYTE_SIZE +: `RDCMP_BYTE_SIZE] = {`RDCMP_BYTE_SIZE{be[lane]}};
      end
      return m;
   endfunction

   // Inputs change 2 ns after the rising edge
   task automatic step_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic wait_for_compares(input int target);
      while (compare_count != target) begin
         step_cycle();
      end
   endtask

   task automatic random_lens();
      burst_lens.delete();
      repeat (GROUP_BURSTS) burst_lens.push_back($urandom_range(8, 1));
   endtask

   // Queue a group of reads, then return all their beats back to back
   task automatic run_bursts(input bit flip_beats, input bit send_compares);
      logic [WAW-1:0] start_words[$];
      logic [DW-1:0]  mask;
      logic [DW-1:0]  flip;
      logic [DW-1:0]  be_next;
      int             total;
      total = 0;
      start_words.delete();
      foreach (burst_lens[b]) begin
         read_req.addr  = AW'($urandom);
         read_req.burst = SW'(burst_lens[b]);
         queue_read_req = 1'b1;
         start_words.push_back(read_req.addr[AW-1 -: WAW]);
         total += burst_lens[b];
         step_cycle();
      end
      queue_read_req = 1'b0;
      if (send_compares) begin
         repeat (total) begin
            queue_compare_req = 1'b1;
            step_cycle();
         end
         queue_compare_req = 1'b0;
      end
      repeat (4) step_cycle();
      foreach (burst_lens[b]) begin
         for (int i = 0; i < burst_lens[b]; i++) begin
            mask        = (`RDCMP_RANDOM_BE == 1) ? lane_mask(be_state) : '1;
            flip        = flip_beats ? (DW'(1) << $urandom_range(DW - 1, 0)) : '0;
            rdata_valid = 1'b1;
            rdata       = data_state ^ flip;
            beat_pnf    = ~(flip & mask);
            beat_addr   = {start_words[b] + WAW'(i), {(AW - WAW){1'b0}}};
            data_state  = lfsr_step(data_state, DW);
            be_next     = lfsr_step(DW'(be_state), BEW);
            be_state    = be_next[BEW-1:0];
            beats_sent++;
            step_cycle();
         end
      end
      rdata_valid = 1'b0;
      rdata       = '0;
      beat_pnf    = '1;
      wait_for_compares(beats_sent);
   endtask

   //////////////////////////////
   // Reference timing model
   //////////////////////////////

   // Beat at edge t shows at t+3, counters and first fail at t+4
   always @(posedge clk) begin
      if (!reset_n) begin
         pipe_valid     <= '0;
         pipe_pnf       <= '1;
         pipe_addr      <= '0;
         req_d1         <= 1'b0;
         req_d2         <= 1'b0;
         beat_d1        <= 1'b0;
         model_credit   <= -1;
         model_compares <= 0;
         model_fails    <= 0;
         model_captured <= 1'b0;
         model_ff_addr  <= '0;
         model_ff_pnf   <= '1;
      end else begin
         pipe_valid <= {pipe_valid[1:0], rdata_valid};
         pipe_pnf   <= {pipe_pnf[1:0], (rdata_valid ? beat_pnf : {DW{1'b1}})};
         pipe_addr  <= {pipe_addr[1:0], beat_addr};
         req_d1     <= queue_compare_req;
         req_d2     <= req_d1;
         beat_d1    <= rdata_valid;
         if (enable && req_d2 && !beat_d1) begin
            model_credit <= model_credit + 1;
         end else if (enable && beat_d1 && !req_d2) begin
            model_credit <= model_credit - 1;
         end
         if (pipe_valid[2]) begin
            model_compares <= model_compares + 1;
         end
         if (pipe_pnf[2] != '1) begin
            model_fails <= model_fails + 1;
            if (!model_captured) begin
               model_captured <= 1'b1;
               model_ff_addr  <= pipe_addr[2];
               model_ff_pnf   <= pipe_pnf[2];
            end
         end
      end
   end

   //////////////////////////////
   // Assertions
   //////////////////////////////

   a_reset_state: assert property (@(posedge clk)
      $rose(reset_n) |-> (compare_empty && !compare_full && (&pnf_per_bit)))
      else fail_run("outputs are not at their reset values after reset");
   a_pnf: assert property (@(posedge clk) disable iff (!reset_n)
      pnf_per_bit == pipe_pnf[2])
      else report_mismatch("pnf_per_bit", $sampled(pnf_per_bit), $sampled(pipe_pnf[2]));
   a_valid: assert property (@(posedge clk) disable iff (!reset_n)
      compare_valid == pipe_valid[2])
      else report_mismatch("compare_valid", $sampled(compare_valid), $sampled(pipe_valid[2]));
   a_count: assert property (@(posedge clk) disable iff (!reset_n)
      compare_count == model_compares)
      else report_mismatch("compare_count", $sampled(compare_count), $sampled(model_compares));
   a_fails: assert property (@(posedge clk) disable iff (!reset_n)
      fail_count == model_fails)
      else report_mismatch("fail_count", $sampled(fail_count), $sampled(model_fails));
   a_captured: assert property (@(posedge clk) disable iff (!reset_n)
      captured_first_fail == model_captured)
      else report_mismatch("captured_first_fail", $sampled(captured_first_fail),
                           $sampled(model_captured));
   a_ff_addr: assert property (@(posedge clk) disable iff (!reset_n)
      model_captured |-> first_fail_addr == model_ff_addr)
      else report_mismatch("first_fail_addr", $sampled(first_fail_addr),
                           $sampled(model_ff_addr));
   a_ff_pnf: assert property (@(posedge clk) disable iff (!reset_n)
      model_captured |-> first_fail_pnf == model_ff_pnf)
      else report_mismatch("first_fail_pnf", $sampled(first_fail_pnf), $sampled(model_ff_pnf));
   a_empty: assert property (@(posedge clk) disable iff (!reset_n)
      compare_empty == (model_credit < 0))
      else report_mismatch("compare_empty", $sampled(compare_empty), $sampled(model_credit < 0));
   a_full: assert property (@(posedge clk) disable iff (!reset_n)
      compare_full == (model_credit >= DEPTH))
      else report_mismatch("compare_full", $sampled(compare_full),
                           $sampled(model_credit >= DEPTH));

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial begin
      #(WATCHDOG_NS);
      fail_run("timeout, the DUT did not finish the tests in time");
   end

   initial begin
      int remaining;
      void'($urandom(32'h7b56));
      reset_n           = 1'b0;
      enable            = 1'b1;
      queue_read_req    = 1'b0;
      read_req          = '0;
      queue_compare_req = 1'b0;
      rdata_valid       = 1'b0;
      rdata             = '0;
      beat_pnf          = '1;
      beat_addr         = '0;
      data_state        = `RDCMP_DATA_SEED;
      be_state          = `RDCMP_BE_SEED;
      beats_sent        = 0;
      error_count       = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      reset_n = 1'b1;
      repeat (2) step_cycle();

      // Matching data, then beats with one flipped bit each
      repeat (CLEAN_GROUPS) begin
         random_lens();
         run_bursts(1'b0, 1'b1);
      end
      repeat (FLIP_GROUPS) begin
         random_lens();
         run_bursts(1'b1, 1'b1);
      end
      if (!captured_first_fail) begin
         fail_run("no failing beat was captured by the flipped bursts");
      end

      // Fill the credit counter past its depth with no data
      repeat (DEPTH + 1) begin
         queue_compare_req = 1'b1;
         step_cycle();
      end
      queue_compare_req = 1'b0;
      while (!compare_full) step_cycle();
      burst_lens.delete();
      remaining = DEPTH + 1;
      while (remaining > 0) begin
         burst_lens.push_back((remaining > 8) ? 8 : remaining);
         remaining -= burst_lens[$];
      end
      run_bursts(1'b0, 1'b0);
      while (!compare_empty) step_cycle();
      repeat (4) step_cycle();

      if (error_count == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         $display("Some tests failed");
         $fatal(1, "errors were reported");
      end
   end

endmodule

//--- filelist.f
+incdir+design
design/mem_txn_pkg.sv
design/check_pkg.sv
design/pattern_lfsr.sv
design/expected_data_gen.sv
design/burst_tracker.sv
design/bit_compare.sv
design/fail_logger.sv
design/read_compare_top.sv
bench/tb_read_compare.sv

//--- Bender.yml
package:
  name: read_compare

export_include_dirs:
  - design

sources:
  - design/mem_txn_pkg.sv
  - design/check_pkg.sv
  - design/pattern_lfsr.sv
  - design/expected_data_gen.sv
  - design/burst_tracker.sv
  - design/bit_compare.sv
  - design/fail_logger.sv
  - design/read_compare_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/tb_read_compare.sv
